// File: cp0.f
verilog/cp0RegPkg.sv
verilog/cp0ExcPkg.sv
verilog/cp0Timer.sv
verilog/cp0Status.sv
verilog/cp0Interrupt.sv
verilog/cp0ExcRecord.sv
verilog/cp0ReadMux.sv
verilog/cp0Top.sv
tests/cp0Tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the CP0 testbench with Verilator, runs it and reports the result by exit status

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not installed or not on PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module cp0Tb -f cp0.f --Mdir obj_dir -o cp0Sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/cp0Sim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: tests/cp0Tb.sv
// Random-stimulus testbench for cp0Top, checks the DUT every cycle against a cycle-accurate model
`timescale 1ns/1ps

module cp0Tb;
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    localparam int countDivide = 2;

    logic        clk;
    logic        rst;
    logic        wrEn;
    regAddr_t    wrAddr;
    logic [31:0] wrData;
    regAddr_t    rdAddr;
    logic [31:0] rdData;
    logic [5:0]  hwInt;
    excType_t    excType;
    logic [31:0] excPc;
    logic        excInDelaySlot;
    logic [31:0] excBadAddr;
    logic [31:0] epc;
    logic        exl;
    logic        intRequest;

    // Model state
    logic [31:0] mCount, mCompare, mEpc, mBadVAddr;
    int          mDiv;
    logic        mTi, mBev, mExl, mIe, mBd;
    logic [7:0]  mIm;
    logic [5:0]  mIpHw;   // IP7..IP2
    logic [1:0]  mIpSw;
    logic [4:0]  mExcCode;
    logic [31:0] lfsr;

    cp0Top uut (
        .clk, .rst, .wrEn, .wrAddr, .wrData, .rdAddr, .rdData, .hwInt,
        .excType, .excPc, .excInDelaySlot, .excBadAddr, .epc, .exl, .intRequest
    );

    always #5 clk = ~clk;

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
        end
        return v;
    endfunction

    // Valid flag in bit 5 above the Cause code
    function automatic logic [5:0] codeFor(excType_t t);
        case (t)
            excInterrupt:     return 6'h20;
            excAddrErrFetch:  return 6'h24;
            excAddrErrLoad:   return 6'h24;
            excAddrErrStore:  return 6'h25;
            excSyscall:       return 6'h28;
            excBreakpoint:    return 6'h29;
            excReservedInstr: return 6'h2a;
            excOverflow:      return 6'h2c;
            excTrap:          return 6'h2d;
            default:          return 6'h00;
        endcase
    endfunction

    function automatic logic [31:0] expRead(regAddr_t a);
        case (a)
            regBadVAddr: return mBadVAddr;
            regCount:    return mCount;
            regCompare:  return mCompare;
            regStatus:   return {9'b0, mBev, 6'b0, mIm, 6'b0, mExl, mIe};
            regCause:    return {mBd, mTi, 14'b0, mIpHw, mIpSw, 1'b0, mExcCode, 2'b0};
            regEpc:      return mEpc;
            regPrId:     return 32'h0000_4220;
            default:     return 32'h0;
        endcase
    endfunction

    function automatic logic expIntReq();
        return mIe && !mExl && (({mIpHw, mIpSw} & mIm) != 8'h0);
    endfunction

    task automatic modelReset();
        mCount = '0;
        mDiv = 0;
        mCompare = '1;
        {mTi, mBev, mExl, mIe, mBd} = 5'b01000;
        {mIm, mIpHw, mIpSw, mExcCode} = '0;
        mEpc = '0;
        mBadVAddr = '0;
    endtask

    // Advances the model over one rising edge with the inputs now driven
    task automatic modelStep();
        logic       hit;
        logic       taken;
        logic       capture;
        logic [5:0] code;
        hit     = (mCount == mCompare);
        taken   = (excType != excNone) && (excType != excRefetch);
        capture = taken && (excType != excEret) && !mExl;   // Old EXL
        code    = codeFor(excType);
        if (wrEn && wrAddr == regCount) begin
            mCount = wrData;
            mDiv = 0;
        end else if (mDiv == countDivide - 1) begin
            mDiv = 0;
            mCount = mCount + 32'd1;
        end else begin
            mDiv = mDiv + 1;
        end
        if (wrEn && wrAddr == regCompare) begin
            mCompare = wrData;
            mTi = 1'b0;
        end else if (hit) begin
            mTi = 1'b1;
        end
        if (wrEn && wrAddr == regStatus) begin
            mBev = wrData[22];
            mIm = wrData[15:8];
            mIe = wrData[0];
        end
        if (taken) begin
            mExl = (excType != excEret);
        end else if (wrEn && wrAddr == regStatus) begin
            mExl = wrData[1];
        end
        mIpHw = hwInt | {hit, 5'b0};
        if (wrEn && wrAddr == regCause) begin
            mIpSw = wrData[9:8];
        end
        if (capture) begin
            mEpc = excInDelaySlot ? excPc - 32'd4 : excPc;
            mBd = excInDelaySlot;
        end else if (wrEn && wrAddr == regEpc) begin
            mEpc = wrData;
        end
        if (code[5]) begin
            mExcCode = code[4:0];
        end
        if (excType == excAddrErrFetch) begin
            mBadVAddr = excPc;
        end else if (excType == excAddrErrLoad || excType == excAddrErrStore) begin
            mBadVAddr = excBadAddr;
        end
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic beginCycle();
        @(negedge clk);
        rst = 1'b0;
        wrEn = 1'b0;
        excType = excNone;
        rdAddr = regAddr_t'(randBits(5));
    endtask

    // Compare the settled outputs and step the model
    task automatic endCycle();
        #1;
        checkEq("rdData", rdData, expRead(rdAddr));
        checkEq("epc", epc, mEpc);
        checkEq("exl", 32'(exl), 32'(mExl));
        checkEq("intRequest", 32'(intRequest), 32'(expIntReq()));
        modelStep();
    endtask

    task automatic writeReg(input regAddr_t a, input logic [31:0] d);
        beginCycle();
        wrEn = 1'b1;
        wrAddr = a;
        wrData = d;
        endCycle();
    endtask

    task automatic commitExc(input excType_t t, input regAddr_t rd);
        beginCycle();
        excType = t;
        excPc = randBits(32) & 32'hFFFF_FFFC;
        excInDelaySlot = 1'(randBits(1));
        excBadAddr = randBits(32);
        rdAddr = rd;
        endCycle();
    endtask

    initial begin
        logic [31:0] base;
        regAddr_t    a;
        logic        seen;
        int          i;
        int          n;
        clk = 1'b0;
        rst = 1'b1;
        wrEn = 1'b0;
        wrAddr = '0;
        wrData = '0;
        rdAddr = '0;
        hwInt = '0;
        excType = excNone;
        excPc = '0;
        excInDelaySlot = 1'b0;
        excBadAddr = '0;
        lfsr = 32'h1b9e_58e5;
        modelReset();
        repeat (10) @(posedge clk);

        // Write and read back writable registers
        for (i = 0; i < 40; i++) begin
            n = int'(randBits(2));
            a = (n == 0) ? regStatus : (n == 1) ? regCause : (n == 2) ? regEpc : regCompare;
            writeReg(a, randBits(32));
            beginCycle();
            rdAddr = a;
            endCycle();
        end

        writeReg(regCount, randBits(32));
        for (i = 0; i < 12; i++) begin
            beginCycle();
            rdAddr = regCount;
            endCycle();
        end

        // Timer interrupt through IM7
        writeReg(regStatus, 32'h0040_8001);
        writeReg(regCause, 32'h0);
        base = randBits(32);
        writeReg(regCount, base);
        writeReg(regCompare, base + 32'd3);
        seen = 1'b0;
        for (i = 0; i < 40 && !seen; i++) begin
            beginCycle();
            rdAddr = regCause;
            endCycle();
            seen = intRequest && rdData[30];
        end
        if (!seen) begin
            $display("timeout: timer interrupt never reached intRequest");
            $display("sim failed");
            $fatal(1);
        end
        beginCycle();
        rdAddr = regCause;
        endCycle();
        writeReg(regCompare, base + 32'd100);
        beginCycle();
        rdAddr = regCause;
        endCycle();
        checkEq("Cause.TI after Compare write", 32'(rdData[30]), 32'd0);

        // Nested exceptions, refetch and ERET
        for (i = 0; i < 25; i++) begin
            commitExc(excEret, regStatus);
            n = int'(randBits(4)) % 9 + 1;
            commitExc(excType_t'(n), regEpc);
            n = int'(randBits(4)) % 9 + 1;
            commitExc(excType_t'(n), regCause);
            commitExc(excRefetch, regBadVAddr);
            beginCycle();
            rdAddr = regCause;
            endCycle();
        end
        commitExc(excEret, regStatus);

        // Hardware and software interrupt lines
        base = randBits(32);
        writeReg(regStatus, (base & 32'h0000_FF00) | 32'h1);
        for (i = 0; i < 80; i++) begin
            beginCycle();
            hwInt = 6'(randBits(6));
            n = int'(randBits(3));
            if (n == 0) begin
                wrEn = 1'b1;
                wrAddr = regCause;
                wrData = randBits(32);
            end else if (n == 1) begin
                wrEn = 1'b1;
                wrAddr = regStatus;
                wrData = randBits(32) & 32'h0040_FF03;
            end
            if (randBits(1) != 0) begin
                rdAddr = regCause;
            end
            endCycle();
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog/cp0ExcPkg.sv
// Exception types committed to CP0 and their mapping to Cause.ExcCode
package cp0ExcPkg;

    typedef enum logic [4:0] {
        excNone,
        excInterrupt,
        excAddrErrFetch,
        excAddrErrLoad,
        excAddrErrStore,
        excSyscall,
        excBreakpoint,
        excReservedInstr,
        excOverflow,
        excTrap,
        excEret,
        excRefetch
    } excType_t;

    typedef logic [4:0] excCode_t;

    localparam excCode_t codeInt  = 5'h00;
    localparam excCode_t codeAdEL = 5'h04;  // Fetch or load address error
    localparam excCode_t codeAdES = 5'h05;
    localparam excCode_t codeSys  = 5'h08;
    localparam excCode_t codeBp   = 5'h09;
    localparam excCode_t codeRi   = 5'h0a;
    localparam excCode_t codeOv   = 5'h0c;
    localparam excCode_t codeTr   = 5'h0d;

    // Eret and refetch are pipeline events without a code
    function automatic logic excHasCode(excType_t t);
        return !(t inside {excNone, excEret, excRefetch});
    endfunction

    function automatic excCode_t excCodeOf(excType_t t);
        case (t)
            excAddrErrFetch,
            excAddrErrLoad:   return codeAdEL;
            excAddrErrStore:  return codeAdES;
            excSyscall:       return codeSys;
            excBreakpoint:    return codeBp;
            excReservedInstr: return codeRi;
            excOverflow:      return codeOv;
            excTrap:          return codeTr;
            default:          return codeInt;
        endcase
    endfunction

    function automatic logic excTaken(excType_t t);
        return (t != excNone) && (t != excRefetch);
    endfunction

endpackage

// File: verilog/cp0ExcRecord.sv
// EPC, Cause.BD, Cause.ExcCode and BadVAddr captured at exception commit, used inside cp0Top
`timescale 1ns/1ps

module cp0ExcRecord (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wrEn,
    input  cp0RegPkg::regAddr_t             wrAddr,
    input  logic [cp0RegPkg::dataWidth-1:0] wrData,
    input  cp0ExcPkg::excType_t             excType,
    input  logic [cp0RegPkg::dataWidth-1:0] excPc,
    input  logic                            excInDelaySlot,
    input  logic [cp0RegPkg::dataWidth-1:0] excBadAddr,
    input  logic                            exl,
    output logic [cp0RegPkg::dataWidth-1:0] epc,
    output logic                            causeBd,
    output cp0ExcPkg::excCode_t             excCode,
    output logic [cp0RegPkg::dataWidth-1:0] badVAddr
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    logic                 capture;
    logic [dataWidth-1:0] restartPc;

    // Nested exceptions keep the first return point
    assign capture   = excTaken(excType) && (excType != excEret) && !exl;
    assign restartPc = excInDelaySlot ? excPc - dataWidth'(4) : excPc;  // Back to the branch

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (capture) begin
            epc <= restartPc;
        end else if (wrEn && (wrAddr == regEpc)) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            causeBd <= 1'b0;
        end else if (capture) begin
            causeBd <= excInDelaySlot;
        end
    end

    // Updated even at exception level
    always_ff @(posedge clk) begin
        if (rst) begin
            excCode <= '0;
        end else if (excHasCode(excType)) begin
            excCode <= excCodeOf(excType);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badVAddr <= '0;
        end else begin
            case (excType)
                excAddrErrFetch: badVAddr <= excPc;
                excAddrErrLoad,
                excAddrErrStore: badVAddr <= excBadAddr;  // Data access address
                default:         badVAddr <= badVAddr;
            endcase
        end
    end

endmodule

// File: verilog/cp0Interrupt.sv
// Pending interrupt bits of Cause and the interrupt request to the pipeline, used inside cp0Top
`timescale 1ns/1ps

module cp0Interrupt (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wrEn,
    input  cp0RegPkg::regAddr_t             wrAddr,
    input  logic [cp0RegPkg::dataWidth-1:0] wrData,
    input  logic [cp0RegPkg::numHwInt-1:0]  hwInt,
    input  logic                            timerHit,
    input  logic [7:0]                      im,
    input  logic                            ie,
    input  logic                            exl,
    output logic [7:0]                      causeIp,
    output logic                            intRequest
);
    import cp0RegPkg::*;

    logic [numHwInt-1:0] ipHw;   // IP7..IP2
    logic [1:0]          ipSw;   // IP1..IP0

    // Timer shares the top hardware line
    always_ff @(posedge clk) begin
        if (rst) begin
            ipHw <= '0;
        end else begin
            ipHw <= hwInt | {timerHit, {(numHwInt - 1){1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ipSw <= '0;
        end else if (wrEn && (wrAddr == regCause)) begin
            ipSw <= wrData[causeIpLsb +: 2];
        end
    end

    assign causeIp    = {ipHw, ipSw};
    assign intRequest = ie && !exl && |(causeIp & im);

endmodule

// File: verilog/cp0ReadMux.sv
// Combinational CP0 read port that packs register fields into their word layouts
`timescale 1ns/1ps

module cp0ReadMux (
    input  cp0RegPkg::regAddr_t             rdAddr,
    input  logic [cp0RegPkg::dataWidth-1:0] count,
    input  logic [cp0RegPkg::dataWidth-1:0] compare,
    input  logic                            bev,
    input  logic [7:0]                      im,
    input  logic                            exl,
    input  logic                            ie,
    input  logic                            causeBd,
    input  logic                            causeTi,
    input  logic [7:0]                      causeIp,
    input  cp0ExcPkg::excCode_t             excCode,
    input  logic [cp0RegPkg::dataWidth-1:0] epc,
    input  logic [cp0RegPkg::dataWidth-1:0] badVAddr,
    output logic [cp0RegPkg::dataWidth-1:0] rdData
);
    import cp0RegPkg::*;

    logic [dataWidth-1:0] statusWord;
    logic [dataWidth-1:0] causeWord;

    always_comb begin
        statusWord                       = '0;
        statusWord[statusBevBit]         = bev;
        statusWord[statusImLsb +: 8]     = im;
        statusWord[statusExlBit]         = exl;
        statusWord[statusIeBit]          = ie;

        causeWord                        = '0;
        causeWord[causeBdBit]            = causeBd;
        causeWord[causeTiBit]            = causeTi;
        causeWord[causeIpLsb +: 8]       = causeIp;
        causeWord[causeExcLsb +: 5]      = excCode;
    end

    always_comb begin
        case (rdAddr)
            regBadVAddr: rdData = badVAddr;
            regCount:    rdData = count;
            regCompare:  rdData = compare;
            regStatus:   rdData = statusWord;
            regCause:    rdData = causeWord;
            regEpc:      rdData = epc;
            regPrId:     rdData = prIdValue;
            default:     rdData = '0;  // Unimplemented registers
        endcase
    end

endmodule

// File: verilog/cp0RegPkg.sv
// CP0 register numbers, field positions and reset values, imported by every CP0 block
package cp0RegPkg;

    localparam int dataWidth = 32;
    localparam int numHwInt  = 6;   // External interrupt lines IP7..IP2

    typedef logic [4:0] regAddr_t;

    // Implemented register numbers
    localparam regAddr_t regBadVAddr = 5'd8;
    localparam regAddr_t regCount    = 5'd9;
    localparam regAddr_t regCompare  = 5'd11;
    localparam regAddr_t regStatus   = 5'd12;
    localparam regAddr_t regCause    = 5'd13;
    localparam regAddr_t regEpc      = 5'd14;
    localparam regAddr_t regPrId     = 5'd15;

    localparam logic [dataWidth-1:0] prIdValue = 32'h0000_4220;

    // Reset values
    localparam logic [dataWidth-1:0] countReset   = '0;
    localparam logic [dataWidth-1:0] compareReset = '1;  // Keeps the timer quiet after reset
    localparam logic                 statusBevReset = 1'b1;

    // Status fields
    localparam int statusBevBit = 22;
    localparam int statusImLsb  = 8;
    localparam int statusExlBit = 1;
    localparam int statusIeBit  = 0;

    // Cause fields
    localparam int causeBdBit  = 31;
    localparam int causeTiBit  = 30;
    localparam int causeIpLsb  = 8;    // IP1..IP0 below IP7..IP2
    localparam int causeExcLsb = 2;

endpackage

// File: verilog/cp0Status.sv
// Status register fields with EXL driven by exception commit and ERET, used inside cp0Top
`timescale 1ns/1ps

module cp0Status (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wrEn,
    input  cp0RegPkg::regAddr_t             wrAddr,
    input  logic [cp0RegPkg::dataWidth-1:0] wrData,
    input  cp0ExcPkg::excType_t             excType,
    output logic                            bev,
    output logic [7:0]                      im,
    output logic                            exl,
    output logic                            ie
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    logic statusWr;

    assign statusWr = wrEn && (wrAddr == regStatus);

    always_ff @(posedge clk) begin
        if (rst) begin
            bev <= statusBevReset;
            im  <= '0;
            ie  <= 1'b0;
        end else if (statusWr) begin
            bev <= wrData[statusBevBit];
            im  <= wrData[statusImLsb +: 8];
            ie  <= wrData[statusIeBit];
        end
    end

    // Commit beats mtc0
    always_ff @(posedge clk) begin
        if (rst) begin
            exl <= 1'b0;
        end else if (excTaken(excType)) begin
            exl <= (excType != excEret);  // Eret leaves exception level
        end else if (statusWr) begin
            exl <= wrData[statusExlBit];
        end
    end

endmodule

// File: verilog/cp0Timer.sv
// Count and Compare timer with its rate divider and sticky Cause.TI, used inside cp0Top
`timescale 1ns/1ps

module cp0Timer #(
    parameter int unsigned countDivide = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wrEn,
    input  cp0RegPkg::regAddr_t             wrAddr,
    input  logic [cp0RegPkg::dataWidth-1:0] wrData,
    output logic [cp0RegPkg::dataWidth-1:0] count,
    output logic [cp0RegPkg::dataWidth-1:0] compare,
    output logic                            timerHit,
    output logic                            causeTi
);
    import cp0RegPkg::*;

    localparam int divWidth = (countDivide > 1) ? $clog2(countDivide) : 1;
    localparam logic [divWidth-1:0] divLast = divWidth'(countDivide - 1);

    logic [divWidth-1:0] divCnt;
    logic                countWr;
    logic                compareWr;
    logic                tick;

    assign countWr   = wrEn && (wrAddr == regCount);
    assign compareWr = wrEn && (wrAddr == regCompare);
    assign tick      = (divCnt == divLast);
    assign timerHit  = (count == compare);

    always_ff @(posedge clk) begin
        if (rst) begin
            divCnt <= '0;
            count  <= countReset;
        end else if (countWr) begin
            divCnt <= '0;      // Restart the rate from the write
            count  <= wrData;
        end else if (tick) begin
            divCnt <= '0;
            count  <= count + 1'b1;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            compare <= compareReset;
        end else if (compareWr) begin
            compare <= wrData;
        end
    end

    // Clear on Compare write wins over a new match
    always_ff @(posedge clk) begin
        if (rst || compareWr) begin
            causeTi <= 1'b0;
        end else if (timerHit) begin
            causeTi <= 1'b1;
        end
    end

endmodule

// File: verilog/cp0Top.sv
// CP0 status and exception block, instantiated by the pipeline with write, read and commit ports
`timescale 1ns/1ps

module cp0Top #(
    parameter int unsigned countDivide = 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wrEn,
    input  cp0RegPkg::regAddr_t                 wrAddr,
    input  logic [cp0RegPkg::dataWidth-1:0]     wrData,
    input  cp0RegPkg::regAddr_t                 rdAddr,
    output logic [cp0RegPkg::dataWidth-1:0]     rdData,
    input  logic [cp0RegPkg::numHwInt-1:0]      hwInt,
    input  cp0ExcPkg::excType_t                 excType,
    input  logic [cp0RegPkg::dataWidth-1:0]     excPc,
    input  logic                                excInDelaySlot,
    input  logic [cp0RegPkg::dataWidth-1:0]     excBadAddr,
    output logic [cp0RegPkg::dataWidth-1:0]     epc,
    output logic                                exl,
    output logic                                intRequest
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    logic [dataWidth-1:0] count;
    logic [dataWidth-1:0] compare;
    logic [dataWidth-1:0] badVAddr;
    logic                 timerHit;
    logic                 causeTi;
    logic                 bev;
    logic [7:0]           im;
    logic                 ie;
    logic [7:0]           causeIp;
    logic                 causeBd;
    excCode_t             excCode;

    cp0Timer #(
        .countDivide(countDivide)
    ) timer (
        .clk, .rst, .wrEn, .wrAddr, .wrData,
        .count, .compare, .timerHit, .causeTi
    );

    cp0Status status (
        .clk, .rst, .wrEn, .wrAddr, .wrData,
        .excType, .bev, .im, .exl, .ie
    );

    cp0Interrupt interrupt (
        .clk, .rst, .wrEn, .wrAddr, .wrData,
        .hwInt, .timerHit, .im, .ie, .exl,
        .causeIp, .intRequest
    );

    cp0ExcRecord excRecord (
        .clk, .rst, .wrEn, .wrAddr, .wrData,
        .excType, .excPc, .excInDelaySlot, .excBadAddr,
        .exl, .epc, .causeBd, .excCode, .badVAddr
    );

    cp0ReadMux readMux (
        .rdAddr,
        .count, .compare,
        .bev, .im, .exl, .ie,
        .causeBd, .causeTi, .causeIp, .excCode,
        .epc, .badVAddr,
        .rdData
    );

endmodule
